// ==== common/exu_pkg.sv ====
package exu_pkg;

  // integer register width
  localparam int XLEN = 64;

  // which unit a micro-op is routed to
  typedef enum logic [1:0] {
    cls_alu,
    cls_bjp,
    cls_ls,
    cls_none
  } op_class_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_lui
  } alu_op_e;

  typedef enum logic [2:0] {
    bjp_jal,
    bjp_jalr,
    bjp_beq,
    bjp_bne,
    bjp_blt,
    bjp_bge,
    bjp_bltu,
    bjp_bgeu
  } bjp_op_e;

  // load sits in bit 0, dword in bit 6
  typedef struct packed {
    logic sz_dword;
    logic sz_word;
    logic sz_half;
    logic sz_byte;
    logic usign;
    logic store;
    logic load;
  } ls_info_t;

  // decoded micro-op entering the stage
  typedef struct packed {
    op_class_e       op_class;
    alu_op_e         alu_op;
    bjp_op_e         bjp_op;
    ls_info_t        ls_info;
    logic            rd_wr_en;
    logic [4:0]      rd_idx;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] jp_op1;
    logic [XLEN-1:0] jp_op2;
    logic            ebreak;
    logic            illegal;
  } exu_uop_t;

  // stage result towards memory and write-back
  typedef struct packed {
    logic            rd_wr_en;
    logic [4:0]      rd_idx;
    logic [XLEN-1:0] wb_data;
    logic            jump_taken;
    logic [XLEN-1:0] jump_addr;
    ls_info_t        ls_info;
    logic [XLEN-1:0] store_data;
    logic            ebreak;
    logic            illegal;
  } exu_res_t;

endpackage

// ==== exu/exu_alu.sv ====
`timescale 1ns/1ps

module exu_alu
  import exu_pkg::*;
(
  input  alu_op_e         alu_op_i,
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  output logic [XLEN-1:0] res_o
);

  logic            sub_need;
  logic [XLEN-1:0] adder_in2;
  logic            adder_cout;
  logic [XLEN-1:0] adder_sum;
  logic [5:0]      shamt;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;
  logic [XLEN-1:0] sra_fill;
  logic            slt_bit;
  logic            sltu_bit;
  logic            sel_add_sub;

  // subtract and both compares share the one adder
  assign sub_need = (alu_op_i == alu_sub) || (alu_op_i == alu_slt) ||
                    (alu_op_i == alu_sltu);
  assign adder_in2 = sub_need ? ~op2_i : op2_i;
  assign {adder_cout, adder_sum} = {1'b0, op1_i} + {1'b0, adder_in2} +
                                   (XLEN + 1)'(sub_need);

  // rv64 shift amount is 6 bits
  assign shamt   = op2_i[5:0];
  assign sll_res = op1_i << shamt;
  assign srl_res = op1_i >> shamt;

  // vacated upper bits take the sign for sra
  assign sra_fill = op1_i[XLEN-1] ? ~({XLEN{1'b1}} >> shamt) : '0;
  assign sra_res  = srl_res | sra_fill;

  // with differing signs the negative op1 is less
  // with equal signs the difference sign decides
  assign slt_bit = (op1_i[XLEN-1] != op2_i[XLEN-1]) ? op1_i[XLEN-1] :
                   adder_sum[XLEN-1];
  // no carry out of a - b means a borrow, so a < b unsigned
  assign sltu_bit = ~adder_cout;

  assign sel_add_sub = (alu_op_i == alu_add) || (alu_op_i == alu_sub);

  assign res_o = ({XLEN{sel_add_sub}}            & adder_sum)
               | ({XLEN{alu_op_i == alu_sll}}    & sll_res)
               | ({XLEN{alu_op_i == alu_slt}}    & XLEN'(slt_bit))
               | ({XLEN{alu_op_i == alu_sltu}}   & XLEN'(sltu_bit))
               | ({XLEN{alu_op_i == alu_xor}}    & (op1_i ^ op2_i))
               | ({XLEN{alu_op_i == alu_srl}}    & srl_res)
               | ({XLEN{alu_op_i == alu_sra}}    & sra_res)
               | ({XLEN{alu_op_i == alu_or}}     & (op1_i | op2_i))
               | ({XLEN{alu_op_i == alu_and}}    & (op1_i & op2_i))
               | ({XLEN{alu_op_i == alu_lui}}    & op2_i);

endmodule

// ==== exu/exu_bju.sv ====
`timescale 1ns/1ps

module exu_bju
  import exu_pkg::*;
(
  input  bjp_op_e         bjp_op_i,
  input  logic            en_i,
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,
  input  logic [XLEN-1:0] jp_op1_i,
  input  logic [XLEN-1:0] jp_op2_i,
  output logic            taken_o,
  output logic [XLEN-1:0] target_o
);

  logic            cmp_eq;
  logic            cmp_lt;
  logic            cmp_ltu;
  logic            cond;
  logic [XLEN-1:0] sum;

  assign cmp_eq  = rs1_i == rs2_i;
  assign cmp_lt  = $signed(rs1_i) < $signed(rs2_i);
  assign cmp_ltu = rs1_i < rs2_i;

  always_comb begin
    case (bjp_op_i)
      bjp_jal,
      bjp_jalr: cond = 1'b1;
      bjp_beq:  cond = cmp_eq;
      bjp_bne:  cond = ~cmp_eq;
      bjp_blt:  cond = cmp_lt;
      bjp_bge:  cond = ~cmp_lt;
      bjp_bltu: cond = cmp_ltu;
      bjp_bgeu: cond = ~cmp_ltu;
      default:  cond = 1'b0;
    endcase
  end

  assign taken_o = en_i & cond;

  // jalr target drops bit 0
  assign sum      = jp_op1_i + jp_op2_i;
  assign target_o = {sum[XLEN-1:1], sum[0] & (bjp_op_i != bjp_jalr)};

endmodule

// ==== exu/exu.sv ====
`timescale 1ns/1ps

module exu
  import exu_pkg::*;
(
  input  exu_uop_t uop_i,
  output exu_res_t res_o
);

  logic            is_bjp;
  logic            is_ls;
  logic            is_jalr;
  alu_op_e         alu_op;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] bju_base;
  logic            bju_taken;
  logic [XLEN-1:0] bju_target;

  assign is_bjp  = uop_i.op_class == cls_bjp;
  assign is_ls   = uop_i.op_class == cls_ls;
  assign is_jalr = is_bjp && (uop_i.bjp_op == bjp_jalr);

  // jumps get the link value pc + 4, loads and stores the address
  assign alu_op = (uop_i.op_class == cls_alu) ? uop_i.alu_op : alu_add;

  exu_alu i_alu (
    .alu_op_i (alu_op),
    .op1_i    (uop_i.op1),
    .op2_i    (uop_i.op2),
    .res_o    (alu_res)
  );

  // jalr is register relative, so its base is rs1 from op1
  assign bju_base = is_jalr ? uop_i.op1 : uop_i.jp_op1;

  exu_bju i_bju (
    .bjp_op_i (uop_i.bjp_op),
    .en_i     (is_bjp),
    .rs1_i    (uop_i.jp_op1),
    .rs2_i    (uop_i.jp_op2),
    .jp_op1_i (bju_base),
    .jp_op2_i (uop_i.jp_op2),
    .taken_o  (bju_taken),
    .target_o (bju_target)
  );

  assign res_o.rd_wr_en   = uop_i.rd_wr_en;
  assign res_o.rd_idx     = uop_i.rd_idx;
  assign res_o.wb_data    = alu_res;
  assign res_o.jump_taken = bju_taken;
  assign res_o.jump_addr  = bju_target;
  assign res_o.ls_info    = is_ls ? uop_i.ls_info : '0;
  // store value rides in jp_op2
  assign res_o.store_data = (is_ls && uop_i.ls_info.store) ? uop_i.jp_op2 : '0;
  assign res_o.ebreak     = uop_i.ebreak;
  assign res_o.illegal    = uop_i.illegal;

endmodule

// ==== logic/pipe_slice.sv ====
`timescale 1ns/1ps

module pipe_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     full_q;
  payload_t data_q;

  // room when empty or when the held entry leaves this cycle
  assign in_ready_o = ~full_q | out_ready_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (in_ready_o) begin
      full_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

endmodule

// ==== logic/exec_top.sv ====
`timescale 1ns/1ps

module exec_top
  import exu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  exu_uop_t in_uop_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output exu_res_t out_res_o
);

  logic     mid_valid;
  logic     mid_ready;
  exu_uop_t mid_uop;
  exu_res_t mid_res;

  pipe_slice #(.payload_t(exu_uop_t)) slice_in (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (in_uop_i),
    .out_valid_o (mid_valid),
    .out_ready_i (mid_ready),
    .out_data_o  (mid_uop)
  );

  // execute sits between the slices with no handshake of its own
  exu i_exu (
    .uop_i (mid_uop),
    .res_o (mid_res)
  );

  pipe_slice #(.payload_t(exu_res_t)) slice_out (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_valid_i  (mid_valid),
    .in_ready_o  (mid_ready),
    .in_data_i   (mid_res),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_res_o)
  );

endmodule

// ==== dv/exec_chk.sv ====
`timescale 1ns/1ps

module exec_chk
  import exu_pkg::*;
(
  input logic     clk,
  input logic     rst_i,
  input logic     in_ready_o,
  input logic     out_valid_o,
  input logic     out_ready_i,
  input exu_res_t out_res_o
);

  // nothing leaves the stage while in reset
  a_idle_in_reset: assert property (@(posedge clk) rst_i |=> !out_valid_o)
    else $error("out_valid_o high after a reset cycle");

  // held result stays put until taken
  a_stall_stable: assert property (@(posedge clk)
    !rst_i && out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_res_o))
    else $error("stalled output changed before acceptance");

  a_ready_after_reset: assert property (@(posedge clk) $fell(rst_i) |-> in_ready_o)
    else $error("in_ready_o low in the first cycle after reset");

endmodule

bind exec_top exec_chk i_chk (
  .clk         (clk),
  .rst_i       (rst_i),
  .in_ready_o  (in_ready_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .out_res_o   (out_res_o)
);

// ==== dv/exec_tb.sv ====
`timescale 1ns/1ps

module exec_tb
  import exu_pkg::*;
();

  // uops per test, summed for the run limit
  localparam int NUM_UOPS       = 11 * 54 + 6 * 5 + 4 + 8 + 8 + 1 + 40;
  localparam int STALL_CYCLES   = 80;
  localparam int TIMEOUT_CYCLES = 2 * (NUM_UOPS + STALL_CYCLES) + 100;

  logic     clk;
  logic     rst_i;
  logic     in_valid_i;
  logic     in_ready_o;
  exu_uop_t in_uop_i;
  logic     out_valid_o;
  logic     out_ready_i;
  exu_res_t out_res_o;

  integer   seed;
  int       cycle_cnt;
  int       chk_cnt;
  int       err_cnt;
  int       misc_err;
  bit       bp_mode;
  exu_res_t exp_q[$];

  exec_top i_dut (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_uop_i    (in_uop_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_res_o   (out_res_o)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout: run went past %0d cycles with %0d results still due",
               TIMEOUT_CYCLES, exp_q.size());
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic check_bit(input string name, input logic exp, input logic act);
    chk_cnt++;
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    chk_cnt++;
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_res(input exu_res_t exp, input exu_res_t act);
    check_bit("rd_wr_en", exp.rd_wr_en, act.rd_wr_en);
    check_word("rd_idx", XLEN'(exp.rd_idx), XLEN'(act.rd_idx));
    check_word("wb_data", exp.wb_data, act.wb_data);
    check_bit("jump_taken", exp.jump_taken, act.jump_taken);
    check_word("jump_addr", exp.jump_addr, act.jump_addr);
    check_word("ls_info", XLEN'(exp.ls_info), XLEN'(act.ls_info));
    check_word("store_data", exp.store_data, act.store_data);
    check_bit("ebreak", exp.ebreak, act.ebreak);
    check_bit("illegal", exp.illegal, act.illegal);
  endtask

  // expected result straight from the execute rules
  function automatic exu_res_t ref_res(input exu_uop_t u);
    exu_res_t        r;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            eq;
    logic            lt;
    logic            ltu;
    r = '0;
    a = u.op1;
    b = u.op2;
    r.rd_wr_en = u.rd_wr_en;
    r.rd_idx   = u.rd_idx;
    r.ebreak   = u.ebreak;
    r.illegal  = u.illegal;
    r.wb_data  = a + b;
    if (u.op_class == cls_alu) begin
      case (u.alu_op)
        alu_sub:  r.wb_data = a - b;
        alu_sll:  r.wb_data = a << b[5:0];
        alu_slt:  r.wb_data = XLEN'($signed(a) < $signed(b));
        alu_sltu: r.wb_data = XLEN'(a < b);
        alu_xor:  r.wb_data = a ^ b;
        alu_srl:  r.wb_data = a >> b[5:0];
        alu_sra:  r.wb_data = $signed(a) >>> b[5:0];
        alu_or:   r.wb_data = a | b;
        alu_and:  r.wb_data = a & b;
        alu_lui:  r.wb_data = b;
        default:  r.wb_data = a + b;
      endcase
    end
    eq  = u.jp_op1 == u.jp_op2;
    lt  = $signed(u.jp_op1) < $signed(u.jp_op2);
    ltu = u.jp_op1 < u.jp_op2;
    if (u.op_class == cls_bjp) begin
      case (u.bjp_op)
        bjp_beq:  r.jump_taken = eq;
        bjp_bne:  r.jump_taken = !eq;
        bjp_blt:  r.jump_taken = lt;
        bjp_bge:  r.jump_taken = !lt;
        bjp_bltu: r.jump_taken = ltu;
        bjp_bgeu: r.jump_taken = !ltu;
        default:  r.jump_taken = 1'b1;
      endcase
    end
    // jalr is relative to rs1 in op1
    if (u.op_class == cls_bjp && u.bjp_op == bjp_jalr) begin
      r.jump_addr = u.op1 + u.jp_op2;
    end else begin
      r.jump_addr = u.jp_op1 + u.jp_op2;
    end
    if (u.bjp_op == bjp_jalr) begin
      r.jump_addr[0] = 1'b0;
    end
    if (u.op_class == cls_ls) begin
      r.ls_info    = u.ls_info;
      r.store_data = u.ls_info.store ? u.jp_op2 : '0;
    end
    return r;
  endfunction

  function automatic exu_uop_t rand_uop(input op_class_e cls);
    exu_uop_t    u;
    logic [31:0] r;
    r = $random(seed);
    u = '0;
    u.op_class = cls;
    u.alu_op   = alu_add;
    u.bjp_op   = bjp_op_e'(r[2:0]);
    u.ls_info  = r[9:3];
    u.rd_wr_en = r[10];
    u.rd_idx   = r[15:11];
    u.ebreak   = r[16];
    u.illegal  = r[17];
    u.op1      = {$random(seed), $random(seed)};
    u.op2      = {$random(seed), $random(seed)};
    u.jp_op1   = {$random(seed), $random(seed)};
    u.jp_op2   = {$random(seed), $random(seed)};
    return u;
  endfunction

  // shift by 63, negative sra, compares across the sign boundary
  function automatic logic [2*XLEN-1:0] edge_pair(input int k);
    case (k)
      0:       return {64'h0, 64'h0};
      1:       return {64'hffff_ffff_ffff_ffff, 64'd63};
      2:       return {64'h8000_0000_0000_0000, 64'd1};
      default: return {64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000};
    endcase
  endfunction

  function automatic logic [2*XLEN-1:0] branch_pair(input int k);
    case (k)
      0:       return {64'd5, 64'd5};
      1:       return {64'd1, 64'd2};
      2:       return {64'd2, 64'd1};
      3:       return {64'hffff_ffff_ffff_ffff, 64'd1};
      default: return {64'd1, 64'hffff_ffff_ffff_ffff};
    endcase
  endfunction

  // one clock, with a fresh random ready under back-pressure
  task automatic step();
    logic [31:0] r;
    @(posedge clk);
    if (bp_mode) begin
      r = $random(seed);
      out_ready_i <= r[0];
    end
  endtask

  task automatic send_uop(input exu_uop_t u);
    in_valid_i <= 1'b1;
    in_uop_i   <= u;
    exp_q.push_back(ref_res(u));
    step();
    while (!in_ready_o) begin
      step();
    end
  endtask

  task automatic drain();
    in_valid_i <= 1'b0;
    while (exp_q.size() != 0) begin
      step();
    end
  endtask

  task automatic report_test(input string name);
    $display("%s finished, %0d errors so far", name, err_cnt + misc_err);
  endtask

  task automatic test_alu();
    exu_uop_t u;
    for (int op = 0; op <= 10; op++) begin
      for (int k = 0; k < 54; k++) begin
        u = rand_uop(cls_alu);
        u.alu_op = alu_op_e'(4'(op));
        if (k < 4) begin
          {u.op1, u.op2} = edge_pair(k);
        end
        send_uop(u);
      end
    end
    drain();
    report_test("alu");
  endtask

  task automatic test_branch();
    exu_uop_t u;
    for (int op = 2; op <= 7; op++) begin
      for (int k = 0; k < 5; k++) begin
        u = rand_uop(cls_bjp);
        u.bjp_op = bjp_op_e'(3'(op));
        {u.jp_op1, u.jp_op2} = branch_pair(k);
        send_uop(u);
      end
    end
    drain();
    report_test("branch");
  endtask

  task automatic test_jump();
    exu_uop_t u;
    for (int k = 0; k < 4; k++) begin
      u = rand_uop(cls_bjp);
      u.bjp_op = k[0] ? bjp_jalr : bjp_jal;
      u.op2    = 64'd4;
      // even base and odd offset so the jalr bit 0 clear shows
      u.op1[0] = 1'b0;
      u.jp_op2 = u.jp_op2 | 64'd1;
      send_uop(u);
    end
    drain();
    report_test("jump");
  endtask

  task automatic test_ls();
    exu_uop_t   u;
    logic [2:0] sel;
    for (int k = 0; k < 8; k++) begin
      sel = k[2:0];
      u = rand_uop(cls_ls);
      u.ls_info       = '0;
      u.ls_info.store = sel[0];
      u.ls_info.load  = ~sel[0];
      u.ls_info.usign = sel[1];
      {u.ls_info.sz_dword, u.ls_info.sz_word, u.ls_info.sz_half,
       u.ls_info.sz_byte} = 4'b0001 << sel[2:1];
      send_uop(u);
    end
    drain();
    report_test("load_store");
  endtask

  task automatic test_passthru();
    for (int k = 0; k < 8; k++) begin
      send_uop(rand_uop(op_class_e'(2'(k))));
    end
    drain();
    report_test("pass_through");
  endtask

  task automatic test_backpressure();
    exu_uop_t    u;
    logic [31:0] r;
    int          lat;
    send_uop(rand_uop(cls_alu));
    in_valid_i <= 1'b0;
    lat = 0;
    do begin
      step();
      lat++;
    end while (!(out_valid_o && out_ready_i) && lat < 10);
    if (lat != 2) begin
      $display("first result left %0d cycles after its accept instead of 2", lat);
      misc_err++;
    end
    drain();
    bp_mode = 1'b1;
    for (int k = 0; k < 40; k++) begin
      u = rand_uop(cls_alu);
      r = $random(seed);
      u.alu_op = alu_op_e'(4'(r % 11));
      send_uop(u);
    end
    drain();
    bp_mode = 1'b0;
    out_ready_i <= 1'b1;
    report_test("backpressure");
  endtask

  // every output transfer is compared in order
  always @(posedge clk) begin
    if (!rst_i && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("%0t: result came out with nothing expected", $time);
        err_cnt++;
      end else begin
        check_res(exp_q.pop_front(), out_res_o);
      end
    end
  end

  initial begin
    seed        = 32'h550b;
    clk         = 1'b0;
    rst_i       = 1'b1;
    in_valid_i  = 1'b0;
    in_uop_i    = '0;
    out_ready_i = 1'b0;
    bp_mode     = 1'b0;
    cycle_cnt   = 0;
    chk_cnt     = 0;
    err_cnt     = 0;
    misc_err    = 0;
    repeat (5) @(posedge clk);
    rst_i <= 1'b0;
    @(posedge clk);
    out_ready_i <= 1'b1;
    test_alu();
    test_branch();
    test_jump();
    test_ls();
    test_passthru();
    test_backpressure();
    $display("checks %0d, errors %0d", chk_cnt, err_cnt + misc_err);
    if (err_cnt == 0 && misc_err == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
common/exu_pkg.sv
exu/exu_alu.sv
exu/exu_bju.sv
exu/exu.sv
logic/pipe_slice.sv
logic/exec_top.sv
dv/exec_chk.sv
dv/exec_tb.sv

// ==== Makefile ====
TOP := exec_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f \
		-Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
